/* source/mxsePkg.sv */
package mxsePkg;

	// Bus address bits 23:1 as the CPU drives them on the FSB
	typedef union packed {
		struct packed {
			logic [3:0] region; // Top four address bits pick the device
			logic [18:0] offset; // Word offset inside a 1 MB region
		} regionView;
		struct packed {
			logic spare; // Bit 23 is never part of a DRAM address
			logic [10:0] row; // Bits 22:12 go out during RAS
			logic [10:0] column; // Bits 11:1 go out during CAS
		} dramView;
	} fsbAddrT;

	// Region codes of the top address nibble
	localparam logic [3:0] regionERamLast = 4'd3; // RAM fills regions 0 through 3
	localparam logic [3:0] regionERom = 4'd4;
	localparam logic [3:0] regionEScsi = 4'd5; // SCSI has no responder in this bridge
	localparam logic [3:0] regionEIoFirst = 4'd8;
	localparam logic [3:0] regionEIoLast = 4'd14; // I/O also ends in a bus error
	localparam logic [3:0] regionEIack = 4'd15; // Interrupt acknowledge space

	// First DRAM row of the top RAM page at 0x3F0000
	localparam logic [10:0] sndPageRow = 11'h3F0;

	// Bus cycle timeouts in FSB clocks
	localparam int timeoutACycles = 8; // Shortest cycle allowed for a sound buffer write
	localparam int timeoutBCycles = 64; // An unanswered cycle gets BERR here
	localparam int cycCntW = $clog2(timeoutBCycles + 1);

	// Refresh pacing
	localparam int refreshPeriod = 128; // Clocks between two refresh requests
	localparam int refreshUrgentCycles = 32; // Waiting this long makes a request urgent
	localparam int refCntW = $clog2(refreshPeriod);
	localparam int urgCntW = $clog2(refreshUrgentCycles + 1);

	// Extra clocks a flash ROM access needs before ready
	localparam int romWaitCycles = 2;

	// Memory controller FSM encodings
	localparam logic [2:0] stIdle = 3'd0;
	localparam logic [2:0] stRow = 3'd1; // RAS is low and the row is on the bus
	localparam logic [2:0] stColumn = 3'd2; // CAS is low and the column is on the bus
	localparam logic [2:0] stDone = 3'd3; // Ready is held until the cycle ends
	localparam logic [2:0] stRefresh = 3'd4;
	localparam logic [2:0] stRomWait = 3'd5;

endpackage

/* source/selectIf.sv */
interface selectIf;
	import mxsePkg::*;

	logic bact; // High from the clock after AS is seen low until AS is seen high
	logic ramCs; // Plain DRAM access
	logic romCs; // Flash ROM access
	logic sndWrCs; // DRAM write into the sound buffer page
	logic iackCs; // Interrupt acknowledge, answered with VPA
	logic noRespCs; // SCSI, I/O or unmapped, answered with BERR
	fsbAddrT addr; // Address latched at the start of the cycle

	// Memory side reads the address and the memory selects
	modport exec (
		input bact, ramCs, romCs, sndWrCs, addr
	);

	// Acknowledge side needs every select
	modport ack (
		input bact, ramCs, romCs, sndWrCs, iackCs, noRespCs
	);

endinterface

/* source/chipSelect.sv */
module chipSelect (
	input logic CLK_FSB,
	input logic rstN,
	input logic [23:1] aFsb,
	input logic nAsFsb,
	input logic nWeFsb,
	selectIf sel
);
	import mxsePkg::*;

	fsbAddrT addrIn;
	logic isRam;
	logic isRom;
	logic isScsi;
	logic isIo;
	logic isIack;
	logic isUnmapped;
	logic isSndWr;
	logic cycleStart;

	assign addrIn = aFsb; // Same bits seen through both union views

	// Region decode of the live address bus
	assign isRam = addrIn.regionView.region <= regionERamLast;
	assign isRom = addrIn.regionView.region == regionERom;
	assign isScsi = addrIn.regionView.region == regionEScsi;
	assign isIo = (addrIn.regionView.region >= regionEIoFirst) &&
		(addrIn.regionView.region <= regionEIoLast);
	assign isIack = addrIn.regionView.region == regionEIack;
	assign isUnmapped = !(isRam || isRom || isScsi || isIo || isIack); // Regions 6 and 7

	// The sound page is found by DRAM row since it spans the top rows of RAM
	assign isSndWr = isRam && (addrIn.dramView.row >= sndPageRow) && !nWeFsb;

	assign cycleStart = !nAsFsb && !sel.bact; // First clock with AS low

	always_ff @(posedge CLK_FSB) begin
		if (!rstN) begin
			sel.bact <= 1'b0;
			sel.ramCs <= 1'b0;
			sel.romCs <= 1'b0;
			sel.sndWrCs <= 1'b0;
			sel.iackCs <= 1'b0;
			sel.noRespCs <= 1'b0;
		end else begin
			sel.bact <= !nAsFsb; // Registered AS marks the whole cycle
			if (cycleStart) begin
				sel.ramCs <= isRam && !isSndWr; // Sound writes get their own select
				sel.romCs <= isRom;
				sel.sndWrCs <= isSndWr;
				sel.iackCs <= isIack;
				sel.noRespCs <= isScsi || isIo || isUnmapped;
			end else if (nAsFsb) begin
				// Selects drop together with bact
				sel.ramCs <= 1'b0;
				sel.romCs <= 1'b0;
				sel.sndWrCs <= 1'b0;
				sel.iackCs <= 1'b0;
				sel.noRespCs <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK_FSB) begin
		if (cycleStart) sel.addr <= addrIn; // CPU keeps the address stable while AS is low
	end

	// A live cycle always has exactly one device selected
	assert property (@(posedge CLK_FSB) disable iff (!rstN)
		sel.bact |-> $onehot({sel.ramCs, sel.romCs, sel.sndWrCs, sel.iackCs, sel.noRespCs}));

endmodule

/* source/cycleCounter.sv */
module cycleCounter (
	input logic CLK_FSB,
	input logic rstN,
	selectIf.exec sel,
	input logic refAck,
	output logic timeoutA,
	output logic timeoutB,
	output logic refReq,
	output logic refUrgent
);
	import mxsePkg::*;

	logic [cycCntW-1:0] cycCnt; // Clocks since bact rose
	logic [refCntW-1:0] refCnt; // Free running refresh interval
	logic [urgCntW-1:0] urgCnt; // Clocks a request has waited

	// Bus cycle length counter saturates at the long timeout
	always_ff @(posedge CLK_FSB) begin
		if (!rstN || !sel.bact) begin
			cycCnt <= '0; // Every new cycle starts from zero
		end else if (cycCnt != cycCntW'(timeoutBCycles)) begin
			cycCnt <= cycCnt + 1'b1;
		end
	end

	assign timeoutA = cycCnt >= cycCntW'(timeoutACycles);
	assign timeoutB = cycCnt == cycCntW'(timeoutBCycles); // Only reachable by saturation

	// Refresh interval and urgency tracking
	always_ff @(posedge CLK_FSB) begin
		if (!rstN) begin
			refCnt <= '0;
			urgCnt <= '0;
			refReq <= 1'b0;
			refUrgent <= 1'b0;
		end else begin
			if (refAck) begin
				refReq <= 1'b0; // Controller has started the refresh
				refUrgent <= 1'b0;
				urgCnt <= '0;
			end else if (refReq && !refUrgent) begin
				if (urgCnt == urgCntW'(refreshUrgentCycles - 1)) refUrgent <= 1'b1;
				else urgCnt <= urgCnt + 1'b1;
			end
			// A new interval tick wins over an ack in the same clock
			if (refCnt == refCntW'(refreshPeriod - 1)) begin
				refCnt <= '0;
				refReq <= 1'b1;
			end else begin
				refCnt <= refCnt + 1'b1;
			end
		end
	end

endmodule

/* source/dramControl.sv */
module dramControl (
	input logic CLK_FSB,
	input logic rstN,
	selectIf.exec sel,
	input logic nLdsFsb,
	input logic nUdsFsb,
	input logic nWeFsb,
	input logic refReq,
	input logic refUrgent,
	output logic refAck,
	output logic ready,
	output logic nRas,
	output logic nCas,
	output logic [11:0] ra,
	output logic nRamLwe,
	output logic nRamUwe,
	output logic nOe,
	output logic nRomCs
);
	import mxsePkg::*;

	logic [2:0] state;
	logic [1:0] waitCnt; // ROM wait count and refresh step share this
	logic ramStart;
	logic romStart;
	logic refStart;
	logic romSel;
	logic ramOe; // Read output enable for the DRAM data phase

	assign ramStart = sel.bact && (sel.ramCs || sel.sndWrCs);
	assign romStart = sel.bact && sel.romCs;
	// Urgent refresh jumps ahead of RAM but lets a ROM cycle go first
	assign refStart = refUrgent ? !romStart : (refReq && !sel.bact);

	// ROM select follows bact directly so it is low one clock after AS
	assign romSel = romStart && (state != stRefresh);
	assign nRomCs = !romSel;
	assign nOe = !(ramOe || (romSel && nWeFsb)); // Output enable only for reads

	always_ff @(posedge CLK_FSB) begin
		if (!rstN) begin
			state <= stIdle;
			waitCnt <= '0;
			refAck <= 1'b0;
			ready <= 1'b0;
			nRas <= 1'b1;
			nCas <= 1'b1;
			ra <= '0;
			nRamLwe <= 1'b1;
			nRamUwe <= 1'b1;
			ramOe <= 1'b0;
		end else begin
			refAck <= 1'b0; // Ack is a single clock pulse
			case (state)
				stIdle: begin
					if (refStart) begin
						nCas <= 1'b0; // CAS before RAS starts the refresh
						refAck <= 1'b1;
						waitCnt <= '0;
						state <= stRefresh;
					end else if (ramStart) begin
						nRas <= 1'b0;
						ra <= {1'b0, sel.addr.dramView.row};
						state <= stRow;
					end else if (romStart) begin
						waitCnt <= 2'(romWaitCycles - 1);
						state <= stRomWait;
					end
				end
				stRow: begin
					ra <= {1'b0, sel.addr.dramView.column}; // Column goes out with CAS
					nCas <= 1'b0;
					nRamLwe <= !(!nWeFsb && !nLdsFsb); // Byte lanes follow the data strobes
					nRamUwe <= !(!nWeFsb && !nUdsFsb);
					ramOe <= nWeFsb;
					state <= stColumn;
				end
				stColumn: begin
					ready <= 1'b1;
					state <= stDone;
				end
				stRomWait: begin
					if (waitCnt > 2'd1) begin
						waitCnt <= waitCnt - 1'b1;
					end else begin
						ready <= 1'b1;
						state <= stDone;
					end
				end
				stDone: begin
					if (!sel.bact) begin
						// Cycle over so close the DRAM access
						ready <= 1'b0;
						nRas <= 1'b1;
						nCas <= 1'b1;
						nRamLwe <= 1'b1;
						nRamUwe <= 1'b1;
						ramOe <= 1'b0;
						state <= stIdle;
					end
				end
				stRefresh: begin
					case (waitCnt)
						2'd0: nRas <= 1'b0; // RAS drops one clock after CAS
						2'd1: ; // RAS stays low a second clock
						default: begin
							nRas <= 1'b1;
							nCas <= 1'b1;
							state <= stIdle;
						end
					endcase
					waitCnt <= waitCnt + 1'b1;
				end
				default: state <= stIdle;
			endcase
		end
	end

	// In a RAM access CAS only falls once RAS is already low
	assert property (@(posedge CLK_FSB) disable iff (!rstN)
		($fell(nCas) && state != stRefresh) |-> $past(!nRas));

	// ROM and DRAM never share a clock
	assert property (@(posedge CLK_FSB) disable iff (!rstN) !(!nRomCs && !nRas));

endmodule

/* source/fsbAck.sv */
module fsbAck (
	input logic CLK_FSB,
	input logic rstN,
	selectIf.ack sel,
	input logic nAsFsb,
	input logic ready,
	input logic timeoutA,
	input logic timeoutB,
	output logic nDtackFsb,
	output logic nVpaFsb,
	output logic nBerrFsb
);

	logic memAck;
	logic sndAck;
	logic dtackSet;
	logic vpaSet;
	logic berrSet;

	assign memAck = (sel.ramCs || sel.romCs) && ready;
	assign sndAck = sel.sndWrCs && ready && timeoutA; // Sound writes are stretched to timeoutA

	assign dtackSet = sel.bact && (memAck || sndAck);
	assign vpaSet = sel.bact && sel.iackCs; // Autovector needs no wait
	assign berrSet = sel.bact && sel.noRespCs && timeoutB; // Nobody answered in time

	always_ff @(posedge CLK_FSB) begin
		if (!rstN || nAsFsb) begin
			// All acks release on the clock after AS is seen high
			nDtackFsb <= 1'b1;
			nVpaFsb <= 1'b1;
			nBerrFsb <= 1'b1;
		end else begin
			// Each ack is sticky until the strobe ends
			if (dtackSet) nDtackFsb <= 1'b0;
			if (vpaSet) nVpaFsb <= 1'b0;
			if (berrSet) nBerrFsb <= 1'b0;
		end
	end

	// One cycle never sees two different terminations
	assert property (@(posedge CLK_FSB) disable iff (!rstN)
		$onehot0({!nDtackFsb, !nVpaFsb, !nBerrFsb}));

endmodule

/* source/fsbBridge.sv */
module fsbBridge (
	input logic CLK_FSB,
	input logic rstN,
	input logic [23:1] aFsb,
	input logic nAsFsb,
	input logic nLdsFsb,
	input logic nUdsFsb,
	input logic nWeFsb,
	output logic nDtackFsb,
	output logic nVpaFsb,
	output logic nBerrFsb,
	output logic nRomCs,
	output logic nRamLwe,
	output logic nRamUwe,
	output logic nRas,
	output logic nCas,
	output logic nOe,
	output logic [11:0] ra
);

	logic timeoutA; // Short timeout for sound buffer writes
	logic timeoutB; // Long timeout that ends unanswered cycles
	logic refReq;
	logic refUrgent;
	logic refAck;
	logic ready; // Memory data phase complete

	selectIf sel ();

	// Decode stage
	chipSelect csU (
		.CLK_FSB(CLK_FSB), .rstN(rstN), .aFsb(aFsb), .nAsFsb(nAsFsb), .nWeFsb(nWeFsb),
		.sel(sel)
	);

	// Execute stage
	cycleCounter cntU (
		.CLK_FSB(CLK_FSB), .rstN(rstN), .sel(sel), .refAck(refAck),
		.timeoutA(timeoutA), .timeoutB(timeoutB), .refReq(refReq), .refUrgent(refUrgent)
	);

	dramControl ramU (
		.CLK_FSB(CLK_FSB), .rstN(rstN), .sel(sel),
		.nLdsFsb(nLdsFsb), .nUdsFsb(nUdsFsb), .nWeFsb(nWeFsb),
		.refReq(refReq), .refUrgent(refUrgent), .refAck(refAck), .ready(ready),
		.nRas(nRas), .nCas(nCas), .ra(ra), .nRamLwe(nRamLwe), .nRamUwe(nRamUwe),
		.nOe(nOe), .nRomCs(nRomCs)
	);

	// Result stage
	fsbAck ackU (
		.CLK_FSB(CLK_FSB), .rstN(rstN), .sel(sel), .nAsFsb(nAsFsb),
		.ready(ready), .timeoutA(timeoutA), .timeoutB(timeoutB),
		.nDtackFsb(nDtackFsb), .nVpaFsb(nVpaFsb), .nBerrFsb(nBerrFsb)
	);

endmodule

/* tests/fsbBridgeTb.sv */
module fsbBridgeTb;
	timeunit 1ns;
	timeprecision 1ps;
	import mxsePkg::*;

	localparam int ramAckEdge = 5; // RAS, CAS and ready each add one clock before DTACK
	localparam int romAckEdge = 1 + romWaitCycles + 1;
	localparam int iackAckEdge = 2;
	localparam int refreshSlack = 4; // CAS, two RAS clocks and one recovery clock
	localparam int totalCycles = 38;
	localparam int watchdogNs = (totalCycles + 4) * (timeoutBCycles + 20) * 4;
	localparam logic [2:0] ackDtack = 3'b011; // Bit order is {nDtack, nVpa, nBerr}
	localparam logic [2:0] ackVpa = 3'b101;
	localparam logic [2:0] ackBerr = 3'b110;
	localparam logic [2:0] ackNone = 3'b111;

	// What the bus driver saw during one cycle
	typedef struct packed {
		logic [23:1] addr;
		logic write, lds, uds;
		logic refreshNear; // CAS seen low outside a RAM access near this cycle
		logic idleAckLow;
		logic sawRow; // A sample with RAS low and CAS still high
		logic [2:0] ackSeen, heldAck, relAck;
		int latency;
		logic [11:0] raRow, raCol;
		logic nRasAck, nCasAck, nLwe, nUwe, nOe, nRomCsAck;
	} cycleObsT;

	typedef struct packed {
		logic [2:0] ack;
		int minLat;
		int maxLat;
		logic isRam;
		logic isRom;
	} expectT;

	logic CLK_FSB;
	logic rstN;
	logic [23:1] aFsb;
	logic nAsFsb, nLdsFsb, nUdsFsb, nWeFsb;
	logic nDtackFsb, nVpaFsb, nBerrFsb;
	logic nRomCs, nRamLwe, nRamUwe, nRas, nCas, nOe;
	logic [11:0] ra;
	cycleObsT obsQ[$]; // Cycles waiting for the compare process
	int issuedCount = 0;
	int comparedCount = 0;

	fsbBridge uut (.*);

	initial begin
		CLK_FSB = 1'b0;
		forever #2 CLK_FSB = ~CLK_FSB; // 4 ns FSB clock
	end

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkAck(input logic [2:0] got, input logic [2:0] exp, input string what);
		if (got !== exp) begin
			reportFailure($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic checkCycles(input int got, input int minV, input int maxV, input string what);
		if (got < minV || got > maxV) begin
			reportFailure($sformatf("ERROR at %0t ns: %s is %0d, expected %0d to %0d",
				$time, what, got, minV, maxV));
		end
	endtask

	task automatic checkStrobe(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			reportFailure($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic checkRa(input logic [11:0] got, input logic [11:0] exp, input string what);
		if (got !== exp) begin
			reportFailure($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	// Expected termination from the memory map as worked out on the byte address
	function automatic expectT expectFor(input logic [23:1] a, input logic write,
		input logic refreshNear);
		expectT e;
		logic [23:0] byteAddr;
		byteAddr = {a, 1'b0};
		e = '0;
		if (byteAddr[23:20] <= 4'd3) begin
			e.ack = ackDtack;
			e.isRam = 1'b1;
			// Writes to the top page are sound buffer writes and wait for timeoutA
			e.minLat = (write && byteAddr >= 24'h3F0000) ? timeoutACycles + 2 : ramAckEdge;
			e.maxLat = e.minLat + refreshSlack; // Refresh may slip in ahead of the RAS
		end else if (byteAddr[23:20] == 4'd4) begin
			e.ack = ackDtack;
			e.isRom = 1'b1;
			e.minLat = romAckEdge;
			e.maxLat = refreshNear ? romAckEdge + refreshSlack : romAckEdge;
		end else if (byteAddr[23:20] == 4'hF) begin
			e.ack = ackVpa;
			e.minLat = iackAckEdge;
			e.maxLat = iackAckEdge;
		end else begin
			e.ack = ackBerr; // SCSI, I/O and the holes have nobody to answer
			e.minLat = timeoutBCycles + 2;
			e.maxLat = timeoutBCycles + 2;
		end
		return e;
	endfunction

	// Kinds are 0 RAM, 1 ROM, 2 iack, 3 no responder, 4 sound page
	function automatic logic [23:1] pickAddr(input int kind);
		logic [23:0] b;
		int r;
		b = 24'($urandom);
		r = $urandom_range(9, 0);
		case (kind)
			0: b[23:22] = 2'd0;
			1: b[23:20] = 4'd4;
			2: b[23:20] = 4'hF;
			3: b[23:20] = (r < 3) ? 4'(5 + r) : 4'(8 + r - 3); // 5 to 7 and then 8 to 14
			default: b[23:16] = 8'h3F;
		endcase
		return b[23:1];
	endfunction

	// One CPU bus cycle from the idle gap to the release of the acknowledge
	task automatic runCycle(input logic [23:1] addr, input logic write, input logic lds,
		input logic uds);
		cycleObsT obs;
		int gap;
		logic acked;
		obs = '0;
		obs.addr = addr;
		obs.write = write;
		obs.lds = lds;
		obs.uds = uds;
		gap = $urandom_range(5, 2);
		repeat (gap) begin
			@(negedge CLK_FSB);
			if (!nCas) obs.refreshNear = 1'b1; // Only a refresh drives CAS with AS high
			if (!nDtackFsb || !nVpaFsb || !nBerrFsb) obs.idleAckLow = 1'b1;
		end
		@(posedge CLK_FSB);
		aFsb <= addr;
		nAsFsb <= 1'b0;
		nLdsFsb <= !lds;
		nUdsFsb <= !uds;
		nWeFsb <= !write;
		acked = 1'b0;
		while (!acked) begin
			@(negedge CLK_FSB); // First sample here is edge 0
			if (!nDtackFsb || !nVpaFsb || !nBerrFsb) begin
				acked = 1'b1;
			end else begin
				if (!nCas && !obs.sawRow) obs.refreshNear = 1'b1;
				if (!nRas && nCas && !obs.sawRow) begin
					obs.sawRow = 1'b1;
					obs.raRow = ra; // Row address goes out while only RAS is low
				end
				obs.latency = obs.latency + 1;
			end
		end
		obs.ackSeen = {nDtackFsb, nVpaFsb, nBerrFsb};
		obs.raCol = ra;
		obs.nRasAck = nRas;
		obs.nCasAck = nCas;
		obs.nLwe = nRamLwe;
		obs.nUwe = nRamUwe;
		obs.nOe = nOe;
		obs.nRomCsAck = nRomCs;
		@(posedge CLK_FSB);
		nAsFsb <= 1'b1;
		nLdsFsb <= 1'b1;
		nUdsFsb <= 1'b1;
		nWeFsb <= 1'b1;
		@(negedge CLK_FSB);
		obs.heldAck = {nDtackFsb, nVpaFsb, nBerrFsb}; // Bridge has not seen AS high yet
		@(negedge CLK_FSB);
		obs.relAck = {nDtackFsb, nVpaFsb, nBerrFsb};
		obsQ.push_back(obs);
		issuedCount++;
	endtask

	// Long idle stretch must show one full CAS before RAS refresh
	task automatic checkIdleRefresh(input int clocks);
		int phase;
		int rasLowCnt;
		phase = 0;
		rasLowCnt = 0;
		repeat (clocks) begin
			@(negedge CLK_FSB);
			if (!nDtackFsb || !nVpaFsb || !nBerrFsb || !nRomCs) begin
				reportFailure("An acknowledge or ROM select went low while the bus was idle");
			end
			case (phase)
				0: if (!nCas && nRas) phase = 1; // CAS leads
				1: begin
					if (!nRas) begin
						phase = 2;
						rasLowCnt = 1;
					end
				end
				2: begin
					if (!nRas) begin
						rasLowCnt++;
					end else begin
						checkStrobe(nCas, 1'b1, "nCas when refresh RAS rises");
						phase = 3;
					end
				end
				default: ;
			endcase
		end
		if (phase != 3) reportFailure("No complete CAS before RAS refresh during the idle stretch");
		checkCycles(rasLowCnt, 2, 2, "refresh RAS low clocks");
	endtask

	// Compare process works through the cycles the driver has finished
	initial begin
		cycleObsT obs;
		expectT exp;
		forever begin
			@(posedge CLK_FSB);
			while (obsQ.size() != 0) begin
				obs = obsQ.pop_front();
				exp = expectFor(obs.addr, obs.write, obs.refreshNear);
				checkStrobe(obs.idleAckLow, 1'b0, "acknowledge low before the cycle");
				checkAck(obs.ackSeen, exp.ack, "acknowledge kind");
				checkCycles(obs.latency, exp.minLat, exp.maxLat, "acknowledge edge");
				checkAck(obs.heldAck, exp.ack, "acknowledge while AS still seen low");
				checkAck(obs.relAck, ackNone, "acknowledge one edge after AS rose");
				if (exp.isRam) begin
					checkStrobe(obs.sawRow, 1'b1, "RAS low ahead of CAS");
					checkStrobe(obs.nRasAck, 1'b0, "nRas at acknowledge");
					checkStrobe(obs.nCasAck, 1'b0, "nCas at acknowledge");
					checkRa(obs.raRow, {1'b0, obs.addr[22:12]}, "ra during RAS");
					checkRa(obs.raCol, {1'b0, obs.addr[11:1]}, "ra during CAS");
					checkStrobe(obs.nLwe, !(obs.write && obs.lds), "nRamLwe");
					checkStrobe(obs.nUwe, !(obs.write && obs.uds), "nRamUwe");
					checkStrobe(obs.nOe, obs.write, "nOe for RAM");
				end else if (exp.isRom) begin
					checkStrobe(obs.nRomCsAck, 1'b0, "nRomCs at acknowledge");
					checkStrobe(obs.nRasAck, 1'b1, "nRas during ROM");
					checkStrobe(obs.nOe, obs.write, "nOe for ROM");
				end else begin
					checkStrobe(obs.nRomCsAck, 1'b1, "nRomCs outside ROM");
				end
				comparedCount++;
			end
		end
	end

	initial begin
		#(watchdogNs);
		reportFailure("Watchdog expired because the bus cycles never finished, the run hung");
	end

	initial begin
		logic [23:1] addr;
		logic [1:0] lanes;
		void'($urandom(32'hd2ca));
		rstN = 1'b0;
		aFsb = '0;
		nAsFsb = 1'b1;
		nLdsFsb = 1'b1;
		nUdsFsb = 1'b1;
		nWeFsb = 1'b1;
		repeat (5) @(posedge CLK_FSB);
		rstN <= 1'b1;
		@(negedge CLK_FSB); // Reset values, no cycle run yet
		checkAck({nDtackFsb, nVpaFsb, nBerrFsb}, ackNone, "acknowledges after reset");
		checkStrobe(nRomCs, 1'b1, "nRomCs after reset");
		checkStrobe(nRamLwe, 1'b1, "nRamLwe after reset");
		checkStrobe(nRamUwe, 1'b1, "nRamUwe after reset");
		checkStrobe(nRas, 1'b1, "nRas after reset");
		checkStrobe(nCas, 1'b1, "nCas after reset");
		checkStrobe(nOe, 1'b1, "nOe after reset");
		checkRa(ra, 12'd0, "ra after reset");
		repeat (12) begin
			addr = pickAddr($urandom_range(3, 1)); // ROM, iack or nobody
			runCycle(addr, $urandom_range(1, 0) == 1, 1'b1, 1'b1);
		end
		repeat (14) begin
			addr = pickAddr(0);
			lanes = 2'($urandom_range(3, 1)); // At least one data strobe
			runCycle(addr, $urandom_range(1, 0) == 1, lanes[0], lanes[1]);
		end
		repeat (3) begin
			addr = pickAddr(4);
			runCycle(addr, 1'b1, 1'b1, 1'b1); // Stretched by timeoutA
			runCycle(addr, 1'b0, 1'b1, 1'b1); // Same address read is plain RAM
		end
		checkIdleRefresh(refreshPeriod + 16);
		repeat (6) begin
			addr = pickAddr(0);
			lanes = 2'($urandom_range(3, 1));
			runCycle(addr, $urandom_range(1, 0) == 1, lanes[0], lanes[1]);
		end
		while (comparedCount != issuedCount) begin
			@(posedge CLK_FSB);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

/* src.f */
source/mxsePkg.sv
source/selectIf.sv
source/chipSelect.sv
source/cycleCounter.sv
source/dramControl.sv
source/fsbAck.sv
source/fsbBridge.sv
tests/fsbBridgeTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module fsbBridgeTb \
	-o fsbBridgeSim
./obj_dir/fsbBridgeSim
